/* dnc_macros.svh */
/*
 * DNC write content weighting shared constants
 * Element, beta and index widths plus the size limits of the key and memory
 */

`ifndef DNC_MACROS_SVH
`define DNC_MACROS_SVH

// Width of one k or M element
`define DNC_DATA_SIZE 16

// Width of the sharpness input
`define DNC_BETA_SIZE 8

// Width of the N and W size inputs
`define DNC_INDEX_SIZE 8

// Largest word width and row count
`define DNC_W_MAX 32
`define DNC_N_MAX 64

// Weight fraction bits, a weight of 1.0 is 2**15
`define DNC_FRAC_BITS 15

// Dot product accumulator, holds 32 full-scale products with sign
`define DNC_ACC_SIZE 40

`endif

/* dnc_pkg.sv */
/*
 * DNC write content weighting types
 * Data, accumulator, score, sum, weight and controller phase types
 */

`default_nettype none

`include "dnc_macros.svh"

package dnc_pkg;

  // Signed element of k or M
  typedef logic signed [`DNC_DATA_SIZE-1:0] dnc_data_t;

  // Signed dot product of one row with k
  typedef logic signed [`DNC_ACC_SIZE-1:0] dnc_acc_t;

  // Clamped dot times beta plus one, never zero
  typedef logic [`DNC_ACC_SIZE+`DNC_BETA_SIZE-1:0] dnc_score_t;

  // Sum of up to N_MAX scores
  typedef logic [`DNC_ACC_SIZE+`DNC_BETA_SIZE+$clog2(`DNC_N_MAX)-1:0] dnc_sum_t;

  // Weight in 1.FRAC format, at most 2**FRAC
  typedef logic [`DNC_FRAC_BITS:0] dnc_weight_t;

  // Row or element count
  typedef logic [`DNC_INDEX_SIZE-1:0] dnc_index_t;

  // Controller phases
  typedef enum logic [2:0] {
    cba_idle,
    cba_key,
    cba_row,
    cba_finish,
    cba_divide,
    cba_output
  } cba_state_e;

endpackage

`default_nettype wire

/* dnc_vector_dot.sv */
/*
 * Streaming dot product unit
 * Signed multiply-accumulate over one row, result presented one cycle
 * after the last element
 */

`default_nettype none

`include "dnc_macros.svh"

module dnc_vector_dot
  import dnc_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      clear,
  input  logic      in_valid,
  input  logic      last,
  input  dnc_data_t a_in,
  input  dnc_data_t b_in,
  output logic      dot_valid,
  output dnc_acc_t  dot_out
);

  ////////////////////
  // Multiplier
  ////////////////////

  // Full precision product of key and row element
  logic signed [2*`DNC_DATA_SIZE-1:0] product;

  // Running sum for the current row
  dnc_acc_t acc;

  assign product = a_in * b_in;

  ////////////////////
  // Accumulator
  ////////////////////

  // Clear restarts the sum with the product of the first element
  always_ff @(posedge clk) begin
    if (in_valid) begin
      if (clear) begin
        acc <= dnc_acc_t'(product);
      end else begin
        acc <= acc + dnc_acc_t'(product);
      end
    end
  end

  // Result strobe, one cycle after the element marked last
  always_ff @(posedge clk) begin
    if (reset) begin
      dot_valid <= 1'b0;
    end else begin
      dot_valid <= in_valid && last;
    end
  end

  // Sum stays put until the next row clears it
  assign dot_out = acc;

  // Row end only on an accepted element
  a_last_valid: assert property (@(posedge clk) disable iff (reset) last |-> in_valid);

endmodule

`default_nettype wire

/* dnc_vector_divider.sv */
/*
 * Sequential restoring divider with four-phase req/ack
 * Quotient is (dividend << FRAC) / divisor, one bit per cycle
 */

`default_nettype none

`include "dnc_macros.svh"

module dnc_vector_divider
  import dnc_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        div_req,
  output logic        div_ack,
  input  dnc_score_t  dividend,
  input  dnc_sum_t    divisor,
  output dnc_weight_t quotient
);

  localparam int frac_bits = `DNC_FRAC_BITS;
  // One guard bit over the divisor for the shifted remainder
  localparam int rem_w = $bits(dnc_sum_t) + 1;
  localparam int cnt_w = $clog2(frac_bits + 1);

  logic             busy;
  logic             load;
  logic [cnt_w-1:0] count;

  // Partial remainder and the numerator bits still to bring down
  logic [rem_w-1:0]   rem;
  logic [frac_bits:0] num_low;

  // Remainder with the next numerator bit shifted in
  logic [rem_w-1:0] trial;
  logic             fits;

  ////////////////////
  // Handshake
  ////////////////////

  // New request only once the previous ack has been withdrawn
  assign load = !busy && div_req && !div_ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      div_ack <= 1'b0;
      count   <= '0;
    end else if (busy) begin
      if (count == cnt_w'(frac_bits)) begin
        busy    <= 1'b0;
        div_ack <= 1'b1;
      end else begin
        count <= count + 1'b1;
      end
    end else if (load) begin
      busy  <= 1'b1;
      count <= '0;
    end else if (!div_req && div_ack) begin
      div_ack <= 1'b0;
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  assign trial = {rem[rem_w-2:0], num_low[frac_bits]};
  assign fits  = trial >= {1'b0, divisor};

  // Numerator is dividend followed by FRAC zeros
  // Its top bits start as remainder, below the divisor since dividend <= divisor
  always_ff @(posedge clk) begin
    if (busy) begin
      rem      <= fits ? trial - {1'b0, divisor} : trial;
      num_low  <= {num_low[frac_bits-1:0], 1'b0};
      quotient <= {quotient[frac_bits-1:0], fits};
    end else if (load) begin
      rem     <= rem_w'(dividend >> 1);
      num_low <= {dividend[0], {frac_bits{1'b0}}};
    end
  end

  // Requester holds req until it has seen ack
  a_req_held: assert property (@(posedge clk) disable iff (reset)
    div_req && !div_ack |=> div_req);

  // A score never exceeds the sum, so the weight stays at or below 1.0
  a_quot_range: assert property (@(posedge clk) disable iff (reset)
    div_ack |-> quotient <= dnc_weight_t'(1 << frac_bits));

endmodule

`default_nettype wire

/* dnc_content_based_addressing.sv */
/*
 * DNC content based addressing core
 * Buffers k, forms a clamped beta-scaled score per memory row, sums the
 * scores and emits each score divided by the sum as a weight
 */

`default_nettype none

`include "dnc_macros.svh"

module dnc_content_based_addressing
  import dnc_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  output logic                      ready,
  input  logic                      k_in_enable,
  output logic                      k_out_enable,
  input  logic                      m_in_k_enable,
  output logic                      m_out_j_enable,
  output logic                      m_out_k_enable,
  output logic                      c_out_enable,
  input  dnc_index_t                size_n_in,
  input  dnc_index_t                size_w_in,
  input  dnc_data_t                 k_in,
  input  dnc_data_t                 m_in,
  input  logic [`DNC_BETA_SIZE-1:0] beta_in,
  output dnc_weight_t               c_out
);

  localparam int key_aw   = $clog2(`DNC_W_MAX);
  localparam int score_aw = $clog2(`DNC_N_MAX);

  cba_state_e state;

  // Operation sizes, stored as last index
  dnc_index_t w_last;
  dnc_index_t n_last;
  logic [`DNC_BETA_SIZE-1:0] beta;

  // Element, row request, score write and output counters
  dnc_index_t k_idx;
  dnc_index_t row_idx;
  dnc_index_t score_idx;
  dnc_index_t out_idx;

  dnc_data_t  key_buf   [`DNC_W_MAX];
  dnc_score_t score_buf [`DNC_N_MAX];
  dnc_sum_t   score_sum;

  logic op_start;
  logic key_take;
  logic elem_take;
  logic elem_last;

  logic       dot_clear;
  logic       dot_last;
  logic       dot_valid;
  dnc_acc_t   dot_out;
  dnc_score_t dot_pos;
  dnc_score_t score;

  logic        div_req;
  logic        div_ack;
  dnc_weight_t quotient;

  ////////////////////
  // Qualifiers
  ////////////////////

  assign op_start  = (state == cba_idle) && ready && start;
  assign key_take  = k_in_enable && k_out_enable;
  assign elem_take = m_in_k_enable && m_out_k_enable;
  assign elem_last = k_idx == w_last;

  // First element restarts the sum, last element closes the row
  assign dot_clear = elem_take && (k_idx == '0);
  assign dot_last  = elem_take && elem_last;

  // Negative similarity clamps to zero, plus one keeps every score nonzero
  assign dot_pos = dot_out[`DNC_ACC_SIZE-1] ? '0 : dnc_score_t'($unsigned(dot_out));
  assign score   = dot_pos * beta + 1'b1;

  ////////////////////
  // Controller FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= cba_idle;
      ready          <= 1'b1;
      k_out_enable   <= 1'b0;
      m_out_j_enable <= 1'b0;
      m_out_k_enable <= 1'b0;
      c_out_enable   <= 1'b0;
      div_req        <= 1'b0;
    end else begin
      // Single-cycle strobes
      m_out_j_enable <= 1'b0;
      c_out_enable   <= 1'b0;
      // Scores land whenever a dot product completes, overlapping the next row
      if (dot_valid) begin
        score_idx <= score_idx + 1'b1;
        score_sum <= score_sum + dnc_sum_t'(score);
      end
      case (state)
        cba_idle: begin
          // Ready returns one cycle after the last weight
          if (!ready) begin
            ready <= 1'b1;
          end else if (op_start) begin
            ready        <= 1'b0;
            k_out_enable <= 1'b1;
            k_idx        <= '0;
            row_idx      <= '0;
            score_idx    <= '0;
            out_idx      <= '0;
            score_sum    <= '0;
            state        <= cba_key;
          end
        end
        cba_key: begin
          if (key_take) begin
            if (elem_last) begin
              k_out_enable   <= 1'b0;
              k_idx          <= '0;
              m_out_j_enable <= 1'b1;
              state          <= cba_row;
            end else begin
              k_idx <= k_idx + 1'b1;
            end
          end
        end
        cba_row: begin
          // Row request pulse, then stream the row
          if (m_out_j_enable) begin
            m_out_k_enable <= 1'b1;
          end
          if (elem_take) begin
            if (elem_last) begin
              m_out_k_enable <= 1'b0;
              k_idx          <= '0;
              if (row_idx == n_last) begin
                state <= cba_finish;
              end else begin
                row_idx        <= row_idx + 1'b1;
                m_out_j_enable <= 1'b1;
              end
            end else begin
              k_idx <= k_idx + 1'b1;
            end
          end
        end
        cba_finish: begin
          // Last dot product is being written this cycle
          if (!dot_valid) begin
            state <= cba_divide;
          end
        end
        cba_divide: begin
          // Four-phase req/ack, req rises only after the old ack is gone
          if (!div_req && !div_ack) begin
            div_req <= 1'b1;
          end else if (div_req && div_ack) begin
            div_req <= 1'b0;
            state   <= cba_output;
          end
        end
        cba_output: begin
          c_out_enable <= 1'b1;
          out_idx      <= out_idx + 1'b1;
          state        <= (out_idx == n_last) ? cba_idle : cba_divide;
        end
        default: state <= cba_idle;
      endcase
    end
  end

  ////////////////////
  // Buffers
  ////////////////////

  always_ff @(posedge clk) begin
    if (op_start) begin
      w_last <= size_w_in - 1'b1;
      n_last <= size_n_in - 1'b1;
      beta   <= beta_in;
    end
    if (key_take) begin
      key_buf[k_idx[key_aw-1:0]] <= k_in;
    end
    if (dot_valid) begin
      score_buf[score_idx[score_aw-1:0]] <= score;
    end
    // Quotient is held by the divider after its ack
    if (state == cba_output) begin
      c_out <= quotient;
    end
  end

  // Key replayed element by element against the row
  dnc_vector_dot dnc_vector_dot_i (
    .clk       (clk),
    .reset     (reset),
    .clear     (dot_clear),
    .in_valid  (elem_take),
    .last      (dot_last),
    .a_in      (key_buf[k_idx[key_aw-1:0]]),
    .b_in      (m_in),
    .dot_valid (dot_valid),
    .dot_out   (dot_out)
  );

  // Sum is final and stable for the whole divide and output phase
  dnc_vector_divider dnc_vector_divider_i (
    .clk      (clk),
    .reset    (reset),
    .div_req  (div_req),
    .div_ack  (div_ack),
    .dividend (score_buf[out_idx[score_aw-1:0]]),
    .divisor  (score_sum),
    .quotient (quotient)
  );

  // Host side protocol
  a_start_ready: assert property (@(posedge clk) disable iff (reset) start |-> ready);
  a_start_sizes: assert property (@(posedge clk) disable iff (reset)
    start |-> (size_n_in inside {[1:`DNC_N_MAX]}) && (size_w_in inside {[1:`DNC_W_MAX]}));
  a_row_stream: assert property (@(posedge clk) disable iff (reset)
    m_in_k_enable |-> m_out_k_enable);

endmodule

`default_nettype wire

/* dnc_write_content_weighting.sv */
/*
 * DNC write content weighting
 * Write head view of the content based addressing core
 */

`default_nettype none

`include "dnc_macros.svh"

module dnc_write_content_weighting
  import dnc_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  output logic                      ready,
  input  logic                      k_in_enable,
  output logic                      k_out_enable,
  input  logic                      m_in_k_enable,
  output logic                      m_out_j_enable,
  output logic                      m_out_k_enable,
  output logic                      c_out_enable,
  input  dnc_index_t                size_n_in,
  input  dnc_index_t                size_w_in,
  input  dnc_data_t                 k_in,
  input  dnc_data_t                 m_in,
  input  logic [`DNC_BETA_SIZE-1:0] beta_in,
  output dnc_weight_t               c_out
);

  // Write key and write strength drive the core directly
  dnc_content_based_addressing dnc_content_based_addressing_i (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .ready          (ready),
    .k_in_enable    (k_in_enable),
    .k_out_enable   (k_out_enable),
    .m_in_k_enable  (m_in_k_enable),
    .m_out_j_enable (m_out_j_enable),
    .m_out_k_enable (m_out_k_enable),
    .c_out_enable   (c_out_enable),
    .size_n_in      (size_n_in),
    .size_w_in      (size_w_in),
    .k_in           (k_in),
    .m_in           (m_in),
    .beta_in        (beta_in),
    .c_out          (c_out)
  );

endmodule

`default_nettype wire

/* tb_dnc_checker.sv */
/*
 * DNC write weighting checker
 * Captures sizes, beta, k and M from the DUT ports and compares every
 * weight with a reference model of the clamped score rule
 */

`default_nettype none

`include "dnc_macros.svh"

module tb_dnc_checker
  import dnc_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  logic                      ready,
  input  logic                      k_in_enable,
  input  logic                      k_out_enable,
  input  logic                      m_in_k_enable,
  input  logic                      m_out_j_enable,
  input  logic                      m_out_k_enable,
  input  logic                      c_out_enable,
  input  dnc_index_t                size_n_in,
  input  dnc_index_t                size_w_in,
  input  dnc_data_t                 k_in,
  input  dnc_data_t                 m_in,
  input  logic [`DNC_BETA_SIZE-1:0] beta_in,
  input  dnc_weight_t               c_out,
  output int                        error_count,
  output int                        weight_count
);

  timeunit 1ns;
  timeprecision 1ps;

  // Operands of the current operation as seen on the ports
  int     key_q [`DNC_W_MAX];
  int     mem_q [`DNC_N_MAX][`DNC_W_MAX];
  int     size_n;
  int     size_w;
  longint beta;

  int   k_cnt;
  int   m_cnt;
  int   out_cnt;
  int   req_cnt;
  int   expected;
  bit   active;
  logic prev_ready;
  logic prev_row_req;

  ////////////////////
  // Reference model
  ////////////////////

  // Beta times the dot product clamped at zero, plus one
  function automatic longint row_score(input int row);
    longint dot;
    dot = 0;
    for (int i = 0; i < size_w; i++) begin
      dot += longint'(key_q[i]) * longint'(mem_q[row][i]);
    end
    if (dot < 0) begin
      dot = 0;
    end
    return dot * beta + 1;
  endfunction

  // Score shifted by FRAC over the sum of all scores, truncated
  function automatic int expected_weight(input int row);
    longint total;
    total = 0;
    for (int r = 0; r < size_n; r++) begin
      total += row_score(r);
    end
    return int'((row_score(row) << `DNC_FRAC_BITS) / total);
  endfunction

  ////////////////////
  // Capture and compare
  ////////////////////

  always @(posedge clk) begin
    if (reset) begin
      error_count  = 0;
      weight_count = 0;
      active       = 0;
      out_cnt      = 0;
      req_cnt      = 0;
    end else begin
      // Ready rising closes the previous operation
      // A new start can follow in the same cycle
      if (active && ready && !prev_ready) begin
        if (out_cnt != size_n) begin
          $display("Operation ended after %0d weights instead of %0d at %0t",
                   out_cnt, size_n, $time);
          error_count++;
        end
        if (req_cnt != size_n) begin
          $display("Operation requested %0d rows instead of %0d at %0t",
                   req_cnt, size_n, $time);
          error_count++;
        end
        active = 0;
      end
      // New operation, sizes are only valid with start
      if (start && ready) begin
        size_n  = int'(size_n_in);
        size_w  = int'(size_w_in);
        beta    = longint'(beta_in);
        k_cnt   = 0;
        m_cnt   = 0;
        out_cnt = 0;
        req_cnt = 0;
        active  = 1;
      end
      if (k_in_enable && k_out_enable && k_cnt < size_w) begin
        key_q[k_cnt] = int'(k_in);
        k_cnt++;
      end
      // Each row request opens the row stream in the next cycle
      if (prev_row_req && !m_out_k_enable) begin
        $display("Row stream did not open after the row request at %0t", $time);
        error_count++;
      end
      if (m_out_j_enable) begin
        req_cnt++;
      end
      // Rows arrive in order, W elements each
      if (m_in_k_enable && m_out_k_enable && m_cnt < size_n * size_w) begin
        mem_q[m_cnt / size_w][m_cnt % size_w] = int'(m_in);
        m_cnt++;
      end
      if (c_out_enable) begin
        if (out_cnt >= size_n) begin
          $display("Weight emitted beyond the row count of %0d at %0t", size_n, $time);
          error_count++;
        end else begin
          expected = expected_weight(out_cnt);
          if (int'(c_out) != expected) begin
            $display("ERROR at %0t: c_out row %0d expected %0d, actual %0d",
                     $time, out_cnt, expected, c_out);
            error_count++;
          end
          weight_count++;
        end
        out_cnt++;
      end
    end
    prev_ready   = ready;
    prev_row_req = m_out_j_enable;
  end

endmodule

`default_nettype wire

/* tb_dnc_write_content_weighting.sv */
/*
 * Testbench for the DNC write content weighting block
 * Directed and random operations with stalls on the key and row streams
 */

`default_nettype none

`include "dnc_macros.svh"

module tb_dnc_write_content_weighting
  import dnc_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  // Cycle limits for one stream element and for a whole operation
  localparam int elem_timeout = 500;
  localparam int op_timeout   = 20000;

  logic                      clk;
  logic                      reset;
  logic                      start;
  logic                      ready;
  logic                      k_in_enable;
  logic                      k_out_enable;
  logic                      m_in_k_enable;
  logic                      m_out_j_enable;
  logic                      m_out_k_enable;
  logic                      c_out_enable;
  dnc_index_t                size_n_in;
  dnc_index_t                size_w_in;
  dnc_data_t                 k_in;
  dnc_data_t                 m_in;
  logic [`DNC_BETA_SIZE-1:0] beta_in;
  dnc_weight_t               c_out;

  int        checker_errors;
  int        weights_compared;
  int        tb_errors;
  int        ops_done;
  bit        aborted;
  integer    seed;
  int        n_rand;
  int        w_rand;
  int        b_rand;
  dnc_data_t key_vals [`DNC_W_MAX];
  dnc_data_t mem_vals [`DNC_N_MAX*`DNC_W_MAX];

  dnc_write_content_weighting u_dut (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .ready          (ready),
    .k_in_enable    (k_in_enable),
    .k_out_enable   (k_out_enable),
    .m_in_k_enable  (m_in_k_enable),
    .m_out_j_enable (m_out_j_enable),
    .m_out_k_enable (m_out_k_enable),
    .c_out_enable   (c_out_enable),
    .size_n_in      (size_n_in),
    .size_w_in      (size_w_in),
    .k_in           (k_in),
    .m_in           (m_in),
    .beta_in        (beta_in),
    .c_out          (c_out)
  );

  tb_dnc_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .ready          (ready),
    .k_in_enable    (k_in_enable),
    .k_out_enable   (k_out_enable),
    .m_in_k_enable  (m_in_k_enable),
    .m_out_j_enable (m_out_j_enable),
    .m_out_k_enable (m_out_k_enable),
    .c_out_enable   (c_out_enable),
    .size_n_in      (size_n_in),
    .size_w_in      (size_w_in),
    .k_in           (k_in),
    .m_in           (m_in),
    .beta_in        (beta_in),
    .c_out          (c_out),
    .error_count    (checker_errors),
    .weight_count   (weights_compared)
  );

  always #5 clk = ~clk;

  ////////////////////
  // Stimulus tasks
  ////////////////////

  task automatic check_level(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s expected %0b, actual %0b", $time, name, expected, actual);
      tb_errors++;
    end
  endtask

  // Pattern mode gives even rows a positive dot and odd rows a negative one
  task automatic fill_data(input int n, input int w, input bit pattern);
    for (int i = 0; i < w; i++) begin
      if (pattern) begin
        key_vals[i] = (i % 2 == 0) ? dnc_data_t'(300 + 13 * i) : dnc_data_t'(-200 - 17 * i);
      end else begin
        key_vals[i] = dnc_data_t'($random(seed));
      end
    end
    for (int j = 0; j < n; j++) begin
      for (int i = 0; i < w; i++) begin
        if (pattern) begin
          mem_vals[j*w+i] = (j % 2 == 0) ? dnc_data_t'(key_vals[i] + j)
                                         : dnc_data_t'(j - key_vals[i]);
        end else begin
          mem_vals[j*w+i] = dnc_data_t'($random(seed));
        end
      end
    end
  endtask

  task automatic wait_ready();
    int waited;
    waited = 0;
    while (!ready && !aborted) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > op_timeout) begin
        $display("Timeout: ready did not return within %0d cycles", op_timeout);
        aborted = 1;
      end
    end
  endtask

  // Key elements only while the DUT asks for them, random gaps when stalling
  task automatic send_key(input int w, input bit stalls);
    int  idx;
    int  waited;
    bit  go;
    idx    = 0;
    waited = 0;
    while (idx < w && !aborted) begin
      go          = k_out_enable && (!stalls || (($random(seed) & 3) != 0));
      k_in_enable = go;
      k_in        = key_vals[idx];
      @(posedge clk);
      #1;
      if (go) begin
        idx++;
        waited = 0;
      end else begin
        waited++;
      end
      if (waited > elem_timeout) begin
        $display("Timeout: key element %0d was never taken", idx);
        aborted = 1;
      end
    end
    k_in_enable = 1'b0;
  endtask

  task automatic send_rows(input int n, input int w, input bit stalls);
    int idx;
    int waited;
    bit go;
    idx    = 0;
    waited = 0;
    while (idx < n * w && !aborted) begin
      go            = m_out_k_enable && (!stalls || (($random(seed) & 3) != 0));
      m_in_k_enable = go;
      m_in          = mem_vals[idx];
      @(posedge clk);
      #1;
      if (go) begin
        idx++;
        waited = 0;
      end else begin
        waited++;
      end
      if (waited > elem_timeout) begin
        $display("Timeout: row element %0d was never taken", idx);
        aborted = 1;
      end
    end
    m_in_k_enable = 1'b0;
  endtask

  // One full operation, start right when ready is seen
  task automatic run_op(input int n, input int w, input int b, input bit stalls,
                        input bit pattern);
    fill_data(n, w, pattern);
    wait_ready();
    if (aborted) begin
      return;
    end
    start     = 1'b1;
    size_n_in = dnc_index_t'(n);
    size_w_in = dnc_index_t'(w);
    beta_in   = b[`DNC_BETA_SIZE-1:0];
    @(posedge clk);
    #1;
    start = 1'b0;
    send_key(w, stalls);
    if (aborted) begin
      return;
    end
    send_rows(n, w, stalls);
    if (aborted) begin
      return;
    end
    wait_ready();
    ops_done++;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    start         = 1'b0;
    k_in_enable   = 1'b0;
    m_in_k_enable = 1'b0;
    size_n_in     = '0;
    size_w_in     = '0;
    k_in          = '0;
    m_in          = '0;
    beta_in       = '0;
    tb_errors     = 0;
    ops_done      = 0;
    aborted       = 0;
    seed          = 50;

    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // Idle state straight out of reset
    check_level("ready", ready, 1'b1);
    check_level("k_out_enable", k_out_enable, 1'b0);
    check_level("m_out_j_enable", m_out_j_enable, 1'b0);
    check_level("m_out_k_enable", m_out_k_enable, 1'b0);
    check_level("c_out_enable", c_out_enable, 1'b0);

    // Single row, uniform weights, mixed sign similarity
    run_op(1, 4, 7, 1'b0, 1'b0);
    run_op(6, 5, 0, 1'b0, 1'b0);
    run_op(8, 6, 3, 1'b0, 1'b1);

    // Random sizes, beta and data with stalls on both streams
    for (int i = 0; i < 12 && !aborted; i++) begin
      n_rand = 1 + ($random(seed) & 63);
      w_rand = 1 + ($random(seed) & 31);
      b_rand = $random(seed) & 255;
      run_op(n_rand, w_rand, b_rand, 1'b1, 1'b0);
    end

    // Back to back, the smaller second operation must not see old data
    run_op(10, 32, 200, 1'b1, 1'b0);
    run_op(3, 2, 5, 1'b0, 1'b0);

    @(posedge clk);
    #1;
    $display("Closing counts: checker errors %0d, testbench errors %0d, weights %0d, ops %0d",
             checker_errors, tb_errors, weights_compared, ops_done);
    if (aborted || tb_errors != 0 || checker_errors != 0) begin
      $display("Checks failed");
    end else begin
      $display("All checks passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
dnc_pkg.sv
dnc_vector_dot.sv
dnc_vector_divider.sv
dnc_content_based_addressing.sv
dnc_write_content_weighting.sv
tb_dnc_checker.sv
tb_dnc_write_content_weighting.sv

/* run.sh */
#!/bin/sh
# Build the DNC write weighting testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module tb_dnc_write_content_weighting -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
